//--- filelist.f
+incdir+hw
hw/core_pkg.sv
hw/core_control.sv
hw/fetch.sv
hw/decode.sv
hw/exec.sv
hw/mem_stage.sv
hw/register_file.sv
hw/uart_tx.sv
hw/core_top.sv
test/core_props.sv
test/core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = core_tb
FILELIST  = filelist.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- test/core_tb.sv
`timescale 1ns/1ps
`include "core_params.svh"

module core_tb;
    import core_pkg::*;

    localparam int half_bit  = 2;
    localparam int bit_clks  = 2 * half_bit;
    localparam int rows      = 4;
    localparam int words     = 16;
    localparam int out_extra = 1 + 20 * half_bit;
    localparam int aw        = $clog2(`CORE_IMEM_DEPTH);

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_word = 3'b010;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    logic          clk;
    logic          rst;
    logic          imem_we;
    logic [aw-1:0] imem_addr;
    logic [31:0]   imem_wdata;
    logic [31:0]   test;
    logic          uart_output;

    logic [31:0] prog [rows][words];
    logic [31:0] exp_x10 [rows];
    logic [7:0]  exp_bytes [rows][2];
    int          exp_nbytes [rows];
    int          n_instr [rows];

    logic [7:0]  rx_bytes [$];
    int          checks;
    int          errors;
    int          cycle;
    int          limit;

    core_top #(.clk_per_half_bit(half_bit)) uut (
        .clk, .rst, .imem_we, .imem_addr, .imem_wdata, .test, .uart_output
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // instruction encoding and program table
    //////////////////////////////////////////////////
    function automatic logic [31:0] encode(input opcode_t op, input logic [2:0] f3,
                                           input logic [6:0] f7, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [31:0] imm);
        logic [31:0] word;
        case (op)
            opc_op:     word = {f7, rs2, rs1, f3, rd, op};
            opc_store:  word = {imm[11:5], rs2, rs1, f3, imm[4:0], op};
            opc_branch: word = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
            opc_lui:    word = {imm[31:12], rd, op};
            opc_jal:    word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
            // I form, also used by out with only rs1 set
            default:    word = {imm[11:0], rs1, f3, rd, op};
        endcase
        return word;
    endfunction

    task automatic build_table();
        logic [31:0] r1, r2, r3, r4, r5, r6, r7, r8;
        for (int r = 0; r < rows; r++) begin
            for (int i = 0; i < words; i++) begin
                prog[r][i] = encode(opc_op_imm, f3_add, 7'd0, 5'd0, 5'd0, 5'd0, 32'd0);
            end
        end
        // arithmetic chain ending in x10
        prog[0][0] = encode(opc_lui, f3_add, 7'd0, 5'd1, 5'd0, 5'd0, 32'h1234_5000);
        prog[0][1] = encode(opc_op_imm, f3_add, 7'd0, 5'd1, 5'd1, 5'd0, 32'h678);
        prog[0][2] = encode(opc_op_imm, f3_add, 7'd0, 5'd2, 5'd0, 5'd0, 32'hffff_fffd);
        prog[0][3] = encode(opc_op, f3_add, 7'd0, 5'd3, 5'd1, 5'd2, 32'd0);
        prog[0][4] = encode(opc_op, f3_add, f7_sub, 5'd4, 5'd1, 5'd2, 32'd0);
        prog[0][5] = encode(opc_op, f3_and, 7'd0, 5'd5, 5'd3, 5'd4, 32'd0);
        prog[0][6] = encode(opc_op, f3_or, 7'd0, 5'd6, 5'd5, 5'd2, 32'd0);
        prog[0][7] = encode(opc_op, f3_xor, 7'd0, 5'd7, 5'd6, 5'd1, 32'd0);
        prog[0][8] = encode(opc_op, f3_slt, 7'd0, 5'd8, 5'd2, 5'd1, 32'd0);
        prog[0][9] = encode(opc_op, f3_add, 7'd0, 5'd10, 5'd7, 5'd8, 32'd0);
        r1 = 32'h1234_5000 + 32'h678;
        r2 = 32'hffff_fffd;
        r3 = r1 + r2;
        r4 = r1 - r2;
        r5 = r3 & r4;
        r6 = r5 | r2;
        r7 = r6 ^ r1;
        r8 = ($signed(r2) < $signed(r1)) ? 32'd1 : 32'd0;
        exp_x10[0] = r7 + r8;
        n_instr[0] = 10;
        exp_nbytes[0] = 0;
        // store two words, load the first one back
        prog[1][0] = encode(opc_op_imm, f3_add, 7'd0, 5'd1, 5'd0, 5'd0, 32'h5a5);
        prog[1][1] = encode(opc_lui, f3_add, 7'd0, 5'd2, 5'd0, 5'd0, 32'habcd_e000);
        prog[1][2] = encode(opc_op_imm, f3_add, 7'd0, 5'd2, 5'd2, 5'd0, 32'h123);
        prog[1][3] = encode(opc_store, f3_word, 7'd0, 5'd0, 5'd0, 5'd2, 32'd8);
        prog[1][4] = encode(opc_store, f3_word, 7'd0, 5'd0, 5'd0, 5'd1, 32'd12);
        prog[1][5] = encode(opc_load, f3_word, 7'd0, 5'd10, 5'd0, 5'd0, 32'd8);
        exp_x10[1] = 32'habcd_e000 + 32'h123;
        n_instr[1] = 6;
        exp_nbytes[1] = 0;
        // bne loop to 5, untaken beq, jal over word 6
        prog[2][0] = encode(opc_op_imm, f3_add, 7'd0, 5'd10, 5'd0, 5'd0, 32'd0);
        prog[2][1] = encode(opc_op_imm, f3_add, 7'd0, 5'd1, 5'd0, 5'd0, 32'd5);
        prog[2][2] = encode(opc_op_imm, f3_add, 7'd0, 5'd10, 5'd10, 5'd0, 32'd1);
        prog[2][3] = encode(opc_branch, f3_bne, 7'd0, 5'd0, 5'd10, 5'd1, 32'hffff_fffc);
        prog[2][4] = encode(opc_branch, f3_beq, 7'd0, 5'd0, 5'd10, 5'd0, 32'd8);
        prog[2][5] = encode(opc_jal, f3_add, 7'd0, 5'd3, 5'd0, 5'd0, 32'd8);
        prog[2][6] = encode(opc_op_imm, f3_add, 7'd0, 5'd10, 5'd0, 5'd0, 32'd99);
        prog[2][7] = encode(opc_op, f3_add, 7'd0, 5'd10, 5'd10, 5'd3, 32'd0);
        exp_x10[2] = 32'd5 + (32'd5 * 32'd4 + 32'd4);
        n_instr[2] = 15;
        exp_nbytes[2] = 0;
        // two serial bytes, then a write that needs the core running again
        prog[3][0] = encode(opc_op_imm, f3_add, 7'd0, 5'd1, 5'd0, 5'd0, 32'h41);
        prog[3][1] = encode(opc_op_imm, f3_add, 7'd0, 5'd2, 5'd0, 5'd0, 32'h2c3);
        prog[3][2] = encode(opc_custom0, f3_add, 7'd0, 5'd0, 5'd1, 5'd0, 32'd0);
        prog[3][3] = encode(opc_custom0, f3_add, 7'd0, 5'd0, 5'd2, 5'd0, 32'd0);
        prog[3][4] = encode(opc_op_imm, f3_add, 7'd0, 5'd10, 5'd0, 5'd0, 32'h77);
        exp_x10[3] = 32'h77;
        n_instr[3] = 5;
        exp_nbytes[3] = 2;
        exp_bytes[3][0] = 8'h41;
        exp_bytes[3][1] = 8'hc3;
    endtask

    function automatic int run_cycles(input int r);
        return 5 * n_instr[r] + out_extra * exp_nbytes[r];
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, expected);
        end
    endtask

    //////////////////////////////////////////////////
    // load, release and check one row
    //////////////////////////////////////////////////
    task automatic run_row(input int r);
        rx_bytes.delete();
        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        for (int i = 0; i < words; i++) begin
            imem_we    <= 1'b1;
            imem_addr  <= aw'(i);
            imem_wdata <= prog[r][i];
            @(posedge clk);
        end
        imem_we <= 1'b0;
        @(negedge clk);
        compare_value($sformatf("row %0d test in reset", r), test, 32'd0);
        compare_value($sformatf("row %0d uart_output in reset", r), {31'b0, uart_output}, 32'd1);
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_value($sformatf("row %0d test after reset", r), test, 32'd0);
        compare_value($sformatf("row %0d uart_output after reset", r),
                      {31'b0, uart_output}, 32'd1);
        repeat (run_cycles(r)) @(posedge clk);
        @(negedge clk);
        compare_value($sformatf("row %0d test", r), test, exp_x10[r]);
        compare_value($sformatf("row %0d uart byte count", r),
                      32'(rx_bytes.size()), 32'(exp_nbytes[r]));
        for (int i = 0; i < exp_nbytes[r] && i < rx_bytes.size(); i++) begin
            compare_value($sformatf("row %0d uart byte %0d", r, i),
                          {24'b0, rx_bytes[i]}, {24'b0, exp_bytes[r][i]});
        end
    endtask

    // samples each bit a little before its middle
    always begin : uart_monitor
        logic [7:0] data;
        @(negedge uart_output);
        repeat (half_bit) @(negedge clk);
        checks++;
        assert (uart_output == 1'b0) else begin
            errors++;
            $display("start bit of a UART frame was not low");
        end
        for (int i = 0; i < 8; i++) begin
            repeat (bit_clks) @(negedge clk);
            data[i] = uart_output;
        end
        repeat (bit_clks) @(negedge clk);
        checks++;
        assert (uart_output == 1'b1) else begin
            errors++;
            $display("stop bit of a UART frame was not high");
        end
        rx_bytes.push_back(data);
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= limit) begin
            $display("timeout: the run went past %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst        = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        checks     = 0;
        errors     = 0;
        cycle      = 0;
        build_table();
        limit = 200;
        for (int r = 0; r < rows; r++) begin
            limit += run_cycles(r);
        end
        for (int r = 0; r < rows; r++) begin
            run_row(r);
        end
        errors += uut.u_props.fail_count;
        $display("checks %0d, errors %0d, property failures %0d",
                 checks, errors, uut.u_props.fail_count);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- test/core_props.sv
`timescale 1ns/1ps

module core_props #(
    parameter int frame_clks = 40
) (
    input logic             clk,
    input logic             rst,
    input core_pkg::state_t state,
    input logic             tx_start,
    input logic             busy,
    input logic             tx
);
    import core_pkg::*;

    int busy_cnt;
    int fail_count = 0;

    function automatic logic legal_next(input state_t prev, input state_t cur);
        case (prev)
            st_fetch:  return cur == st_decode;
            st_decode: return cur == st_exec;
            st_exec:   return cur == st_mem || cur == st_out;
            st_out:    return cur == st_out || cur == st_mem;
            st_mem:    return cur == st_wb;
            st_wb:     return cur == st_fetch;
            default:   return 1'b0;
        endcase
    endfunction

    // cycles spent busy in the current frame
    always_ff @(posedge clk) begin
        if (rst || !busy) begin
            busy_cnt <= 0;
        end else begin
            busy_cnt <= busy_cnt + 1;
        end
    end

    //////////////////////////////////////////////////
    // sequencer and transmitter rules
    //////////////////////////////////////////////////
    a_state: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> legal_next($past(state), state))
        else begin
            fail_count++;
            $error("sequencer took an illegal transition");
        end

    // the transmitter must be idle at the pulse and busy right after it
    a_start_pulse: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !busy ##1 (busy && !tx_start && state == st_out))
        else begin
            fail_count++;
            $error("tx_start was not a single pulse that started the idle transmitter");
        end

    a_frame_len: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> busy_cnt == frame_clks)
        else begin
            fail_count++;
            $error("busy fell before the frame had shifted out");
        end

    // the stop bit is the last tenth of the frame
    a_idle_high: assert property (@(posedge clk) disable iff (rst)
        (!busy || busy_cnt >= frame_clks - frame_clks / 10) |-> tx)
        else begin
            fail_count++;
            $error("serial line low while transmitter idle or in the stop bit");
        end

endmodule

bind core_top core_props #(.frame_clks(20 * clk_per_half_bit)) u_props (
    .clk, .rst, .state, .tx_start, .busy, .tx(uart_output)
);

//--- hw/core_top.sv
`timescale 1ns/1ps
`include "core_params.svh"

module core_top #(
    parameter int clk_per_half_bit = `CORE_HALF_BIT_DEFAULT
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        imem_we,
    input  logic [5:0]  imem_addr,
    input  logic [31:0] imem_wdata,
    output logic [31:0] test,
    output logic        uart_output
);
    import core_pkg::*;

    state_t                 state;
    logic [`CORE_XLEN-1:0]  pc;
    logic [31:0]            instr;
    logic                   tx_start, busy, wb_strobe;

    logic [`CORE_XLEN-1:0]  imm;
    alu_op_t                alu_op;
    logic                   alu_src_imm, alu_src_pc, is_branch, branch_ne, is_jal;
    logic                   mem_read, mem_write, reg_write, is_out;
    logic [4:0]             rs1, rs2, rd;

    logic [`CORE_XLEN-1:0]  rs1_data, rs2_data;
    logic [`CORE_XLEN-1:0]  alu_result, store_data, branch_target;
    logic                   take_branch;

    logic                   wb_en, rf_we;
    logic [4:0]             wb_reg;
    logic [`CORE_XLEN-1:0]  wb_data;

    // register write only lands in st_wb
    assign rf_we = wb_strobe & wb_en;

    core_control u_control (
        .clk, .rst, .is_out, .take_branch, .branch_target, .busy,
        .state, .pc, .tx_start, .wb_strobe
    );

    fetch u_fetch (
        .clk, .state, .pc, .imem_we, .imem_addr, .imem_wdata, .instr
    );

    decode u_decode (
        .clk, .rst, .state, .instr, .imm, .alu_op, .alu_src_imm, .alu_src_pc,
        .is_branch, .branch_ne, .is_jal, .mem_read, .mem_write, .reg_write,
        .is_out, .rs1, .rs2, .rd
    );

    exec u_exec (
        .clk, .state, .pc, .imm, .alu_op, .alu_src_imm, .alu_src_pc,
        .is_branch, .branch_ne, .is_jal, .rs1_data, .rs2_data,
        .alu_result, .store_data, .take_branch, .branch_target
    );

    mem_stage u_mem (
        .clk, .state, .mem_read, .mem_write, .reg_write, .rd,
        .alu_result, .store_data, .wb_en, .wb_reg, .wb_data
    );

    register_file u_regs (
        .clk, .rst, .rs1, .rs2, .rd(wb_reg), .wd(wb_data), .we(rf_we),
        .rs1_data, .rs2_data, .test
    );

    uart_tx #(.clk_per_half_bit(clk_per_half_bit)) u_uart (
        .clk, .rst, .data(rs1_data[7:0]), .start(tx_start), .busy,
        .tx(uart_output)
    );

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps
`include "core_params.svh"

module uart_tx #(
    parameter int clk_per_half_bit = `CORE_HALF_BIT_DEFAULT
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] data,
    input  logic       start,
    output logic       busy,
    output logic       tx
);
    localparam int bit_clks = 2 * clk_per_half_bit;
    localparam int cw       = $clog2(bit_clks);

    logic [cw-1:0] clk_cnt;
    logic [3:0]    bit_cnt;
    logic [9:0]    frame;
    logic          bit_end;

    assign bit_end = (clk_cnt == cw'(bit_clks - 1));
    // idle line is high
    assign tx      = busy ? frame[0] : 1'b1;

    //////////////////////////////////////////////////
    // bit timing
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (start) begin
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            // ten bits including start and stop
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // shift frame, LSB first
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            frame <= {1'b1, data, 1'b0};
        end else if (busy && bit_end) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

endmodule

//--- hw/register_file.sv
`timescale 1ns/1ps
`include "core_params.svh"

module register_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [4:0]            rs1,
    input  logic [4:0]            rs2,
    input  logic [4:0]            rd,
    input  logic [`CORE_XLEN-1:0] wd,
    input  logic                  we,
    output logic [`CORE_XLEN-1:0] rs1_data,
    output logic [`CORE_XLEN-1:0] rs2_data,
    output logic [`CORE_XLEN-1:0] test
);
    logic [`CORE_XLEN-1:0] regs [32];

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];
    // x10 (a0) is the observed result
    assign test     = regs[10];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;
        end
    end

endmodule

//--- hw/mem_stage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module mem_stage #(
    localparam int aw = $clog2(`CORE_DMEM_DEPTH)
) (
    input  logic                  clk,
    input  core_pkg::state_t      state,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  reg_write,
    input  logic [4:0]            rd,
    input  logic [`CORE_XLEN-1:0] alu_result,
    input  logic [`CORE_XLEN-1:0] store_data,
    output logic                  wb_en,
    output logic [4:0]            wb_reg,
    output logic [`CORE_XLEN-1:0] wb_data
);
    import core_pkg::*;

    logic [`CORE_XLEN-1:0] dmem [`CORE_DMEM_DEPTH];
    logic [aw-1:0]         word;

    // word address, byte offset ignored
    assign word = alu_result[2 +: aw];

    always_ff @(posedge clk) begin
        if (state == st_mem) begin
            if (mem_write) begin
                dmem[word] <= store_data;
            end
            wb_en   <= reg_write;
            wb_reg  <= rd;
            wb_data <= mem_read ? dmem[word] : alu_result;
        end
    end

endmodule

//--- hw/exec.sv
`timescale 1ns/1ps
`include "core_params.svh"

module exec (
    input  logic                  clk,
    input  core_pkg::state_t      state,
    input  logic [`CORE_XLEN-1:0] pc,
    input  logic [`CORE_XLEN-1:0] imm,
    input  core_pkg::alu_op_t     alu_op,
    input  logic                  alu_src_imm,
    input  logic                  alu_src_pc,
    input  logic                  is_branch,
    input  logic                  branch_ne,
    input  logic                  is_jal,
    input  logic [`CORE_XLEN-1:0] rs1_data,
    input  logic [`CORE_XLEN-1:0] rs2_data,
    output logic [`CORE_XLEN-1:0] alu_result,
    output logic [`CORE_XLEN-1:0] store_data,
    output logic                  take_branch,
    output logic [`CORE_XLEN-1:0] branch_target
);
    import core_pkg::*;

    operand_src_t          b_src;
    logic [`CORE_XLEN-1:0] a, b, result;
    logic                  equal;

    // jal links pc + 4 through the adder
    assign b_src = alu_src_pc ? src_pc4 : (alu_src_imm ? src_imm : src_reg);
    assign a     = alu_src_pc ? pc : rs1_data;
    assign equal = (rs1_data == rs2_data);

    always_comb begin
        case (b_src)
            src_imm: b = imm;
            src_pc4: b = `CORE_XLEN'd4;
            default: b = rs2_data;
        endcase
        case (alu_op)
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_slt:    result = {31'b0, $signed(a) < $signed(b)};
            alu_pass_b: result = b;
            default:    result = a + b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == st_exec) begin
            alu_result    <= result;
            store_data    <= rs2_data;
            take_branch   <= is_jal | (is_branch & (equal ^ branch_ne));
            branch_target <= pc + imm;
        end
    end

endmodule

//--- hw/decode.sv
`timescale 1ns/1ps
`include "core_params.svh"

module decode (
    input  logic                  clk,
    input  logic                  rst,
    input  core_pkg::state_t      state,
    input  logic [31:0]           instr,
    output logic [`CORE_XLEN-1:0] imm,
    output core_pkg::alu_op_t     alu_op,
    output logic                  alu_src_imm,
    output logic                  alu_src_pc,
    output logic                  is_branch,
    output logic                  branch_ne,
    output logic                  is_jal,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  reg_write,
    output logic                  is_out,
    output logic [4:0]            rs1,
    output logic [4:0]            rs2,
    output logic [4:0]            rd
);
    import core_pkg::*;

    opcode_t    opc;
    logic [2:0] f3;
    logic       f3_ok;

    assign opc   = opcode_t'(instr[6:0]);
    assign f3    = instr[14:12];
    assign f3_ok = f3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};

    function automatic alu_op_t funct_alu(input logic [2:0] f, input logic sub);
        case (f)
            3'b010:  return alu_slt;
            3'b100:  return alu_xor;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            default: return sub ? alu_sub : alu_add;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_op      <= alu_add;
            alu_src_imm <= 1'b0;
            alu_src_pc  <= 1'b0;
            is_branch   <= 1'b0;
            branch_ne   <= 1'b0;
            is_jal      <= 1'b0;
            mem_read    <= 1'b0;
            mem_write   <= 1'b0;
            reg_write   <= 1'b0;
            is_out      <= 1'b0;
        end else if (state == st_decode) begin
            // defaults give a no-op for anything not listed
            alu_op      <= alu_add;
            alu_src_imm <= 1'b0;
            alu_src_pc  <= 1'b0;
            is_branch   <= 1'b0;
            branch_ne   <= f3[0];
            is_jal      <= 1'b0;
            mem_read    <= 1'b0;
            mem_write   <= 1'b0;
            reg_write   <= 1'b0;
            is_out      <= 1'b0;
            imm         <= {{20{instr[31]}}, instr[31:20]};
            case (opc)
                opc_lui: begin
                    alu_op      <= alu_pass_b;
                    alu_src_imm <= 1'b1;
                    reg_write   <= 1'b1;
                    imm         <= {instr[31:12], 12'b0};
                end
                opc_op_imm: begin
                    alu_op      <= funct_alu(f3, 1'b0);
                    alu_src_imm <= 1'b1;
                    reg_write   <= f3_ok;
                end
                opc_op: begin
                    alu_op    <= funct_alu(f3, instr[30]);
                    reg_write <= f3_ok;
                end
                opc_load: begin
                    alu_src_imm <= 1'b1;
                    mem_read    <= (f3 == 3'b010);
                    reg_write   <= (f3 == 3'b010);
                end
                opc_store: begin
                    alu_src_imm <= 1'b1;
                    mem_write   <= (f3 == 3'b010);
                    imm         <= {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
                opc_branch: begin
                    // beq and bne only
                    is_branch <= (f3[2:1] == 2'b00);
                    imm       <= {{19{instr[31]}}, instr[31], instr[7],
                                  instr[30:25], instr[11:8], 1'b0};
                end
                opc_jal: begin
                    is_jal     <= 1'b1;
                    alu_src_pc <= 1'b1;
                    reg_write  <= 1'b1;
                    imm        <= {{11{instr[31]}}, instr[31], instr[19:12],
                                   instr[20], instr[30:21], 1'b0};
                end
                opc_custom0: is_out <= 1'b1;
                default: ;
            endcase
        end
    end

    // register indices are plain fields
    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            rs1 <= instr[19:15];
            rs2 <= instr[24:20];
            rd  <= instr[11:7];
        end
    end

endmodule

//--- hw/fetch.sv
`timescale 1ns/1ps
`include "core_params.svh"

module fetch #(
    localparam int aw = $clog2(`CORE_IMEM_DEPTH)
) (
    input  logic                  clk,
    input  core_pkg::state_t      state,
    input  logic [`CORE_XLEN-1:0] pc,
    input  logic                  imem_we,
    input  logic [aw-1:0]         imem_addr,
    input  logic [31:0]           imem_wdata,
    output logic [31:0]           instr
);
    import core_pkg::*;

    logic [31:0] imem [`CORE_IMEM_DEPTH];

    // load port, only used while the core sits in reset
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch) begin
            instr <= imem[pc[2 +: aw]];
        end
    end

endmodule

//--- hw/core_control.sv
`timescale 1ns/1ps
`include "core_params.svh"

module core_control (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  is_out,
    input  logic                  take_branch,
    input  logic [`CORE_XLEN-1:0] branch_target,
    input  logic                  busy,
    output core_pkg::state_t      state,
    output logic [`CORE_XLEN-1:0] pc,
    output logic                  tx_start,
    output logic                  wb_strobe
);
    import core_pkg::*;

    // pulse on the edge that enters st_out, so busy is already up there
    assign tx_start  = (state == st_exec) && is_out;
    assign wb_strobe = (state == st_wb);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_fetch;
            pc    <= '0;
        end else begin
            case (state)
                st_fetch:  state <= st_decode;
                st_decode: state <= st_exec;
                st_exec:   state <= is_out ? st_out : st_mem;
                st_out: begin
                    // hold until the frame has gone out
                    if (!busy) begin
                        state <= st_mem;
                    end
                end
                st_mem:    state <= st_wb;
                st_wb: begin
                    pc    <= take_branch ? branch_target : pc + `CORE_XLEN'd4;
                    state <= st_fetch;
                end
                default:   state <= st_fetch;
            endcase
        end
    end

endmodule

//--- hw/core_pkg.sv
package core_pkg;

    // sequencer state, one per clock
    typedef enum logic [2:0] {
        st_fetch  = 3'd0,
        st_decode = 3'd1,
        st_exec   = 3'd2,
        st_mem    = 3'd3,
        st_wb     = 3'd4,
        st_out    = 3'd5
    } state_t;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_pass_b = 4'd6
    } alu_op_t;

    // major opcodes, custom0 carries out
    typedef enum logic [6:0] {
        opc_lui     = 7'b0110111,
        opc_op_imm  = 7'b0010011,
        opc_op      = 7'b0110011,
        opc_load    = 7'b0000011,
        opc_store   = 7'b0100011,
        opc_branch  = 7'b1100011,
        opc_jal     = 7'b1101111,
        opc_custom0 = 7'b0001011
    } opcode_t;

    // second ALU operand source
    typedef enum logic [1:0] {
        src_reg = 2'd0,
        src_imm = 2'd1,
        src_pc4 = 2'd2
    } operand_src_t;

endpackage

//--- hw/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address width
`define CORE_XLEN 32

// memory depths in 32-bit words
`define CORE_IMEM_DEPTH 64
`define CORE_DMEM_DEPTH 64

// clocks per half UART bit
`define CORE_HALF_BIT_DEFAULT 434

`endif
